// File: rtl/activationReplay.sv
`timescale 1ns/1ns

module activationReplay
	import mvuGeomPkg::*, mvuDataPkg::*;
(
	input logic clk,
	input logic rst,
	input logic inValid,
	input actVec_t inData,
	output logic inCredit,
	input logic outValid,	// Result leaves the core
	input logic outCreditReturn,
	output logic issue,
	output nfIdx_t nfIdx,
	output sfIdx_t sfIdx,
	mvuLaneIf.actSide lane
);
	replayState_t state;
	actVec_t actBuf [SF];	// One vector, one word per synapse fold
	sfIdx_t wrPtr;
	logic [$clog2(SF+1)-1:0] stored;	// Words of the pending vector
	credit_t outCredits;	// Results we may still start
	credit_t inFlight;	// Folds started, result not yet out
	logic full;
	logic lastBeat;
	logic vecDone;
	logic wantFold;
	logic startFold;

	assign full = stored == SF;
	assign issue = state == issuing;
	assign lastBeat = issue && sfIdx == sfIdx_t'(SF - 1);
	assign vecDone = lastBeat && nfIdx == nfIdx_t'(NF - 1);

	// A fold may begin from a full buffer, after a stall, or right behind the previous fold
	assign wantFold = (state == loading && full) || state == waitCredit || (lastBeat && !vecDone);
	assign startFold = wantFold && outCredits != '0;

	// Input words land in column order
	always_ff @(posedge clk) begin
		if (inValid) begin
			actBuf[wrPtr] <= inData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			stored <= '0;
		end else begin
			if (inValid) begin
				wrPtr <= (wrPtr == sfIdx_t'(SF - 1)) ? '0 : wrPtr + 1'b1;
			end
			// Producer holds no credit while the buffer is full, so no write collides here
			if (state == loading && full) begin
				stored <= '0;
			end else if (inValid) begin
				stored <= stored + 1'b1;
			end
		end
	end

	// Fold sequencing
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= loading;
			nfIdx <= '0;
			sfIdx <= '0;
		end else begin
			case (state)
				loading: begin
					if (full) begin
						state <= startFold ? issuing : waitCredit;
					end
				end
				waitCredit: begin
					if (startFold) begin
						state <= issuing;
					end
				end
				issuing: begin
					if (!lastBeat) begin
						sfIdx <= sfIdx + 1'b1;
					end else begin
						sfIdx <= '0;
						if (vecDone) begin
							nfIdx <= '0;
							state <= loading;	// Wait for the next vector
						end else begin
							nfIdx <= nfIdx + 1'b1;
							state <= startFold ? issuing : waitCredit;
						end
					end
				end
				default: state <= loading;
			endcase
		end
	end

	// Credits, both directions
	always_ff @(posedge clk) begin
		if (rst) begin
			outCredits <= credit_t'(OUT_CREDITS);
			inFlight <= '0;
			inCredit <= 1'b0;
		end else begin
			outCredits <= outCredits + credit_t'(outCreditReturn) - credit_t'(startFold);
			inFlight <= inFlight + credit_t'(startFold) - credit_t'(outValid);
			inCredit <= issue && nfIdx == nfIdx_t'(NF - 1);	// Slot read for the last time
		end
	end

	// Lane beat, aligned with the registered weight read
	always_ff @(posedge clk) begin
		if (rst) begin
			lane.beat <= 1'b0;
			lane.last <= 1'b0;
		end else begin
			lane.beat <= issue;
			lane.last <= lastBeat;
		end
	end

	always_ff @(posedge clk) begin
		lane.act <= actBuf[sfIdx];
	end

	assign lane.zero = !lane.beat;	// Idle cycles add nothing

	// Credits held plus results in the pipe never exceed the grant
	creditBound: assert property (@(posedge clk) disable iff (rst)
		outCredits + inFlight <= OUT_CREDITS);

	// First beat of a fold follows a cycle with a credit in hand
	foldHasCredit: assert property (@(posedge clk) disable iff (rst)
		issue && sfIdx == '0 |-> $past(outCredits) != '0);

	// Every core result belongs to a fold we started
	resultExpected: assert property (@(posedge clk) disable iff (rst)
		outValid |-> inFlight != '0);

endmodule

// File: rtl/mvuDataPkg.sv
package mvuDataPkg;
	import mvuGeomPkg::*;

	// Element widths
	localparam int ACT_W = 4;
	localparam int WEIGHT_W = 4;
	localparam int ACCU_W = 16;
	localparam int PROD_W = ACT_W + WEIGHT_W;	// Signed x unsigned product fits here

	typedef logic [ACT_W-1:0] act_t;	// Unsigned activation
	typedef logic signed [WEIGHT_W-1:0] weight_t;	// Signed weight
	typedef logic signed [ACCU_W-1:0] accu_t;	// Row accumulator

	// Column s sits at bits s*ACT_W, lowest column in the low bits
	typedef logic [SIMD*ACT_W-1:0] actVec_t;
	// Row r, column s sits at bits (r*SIMD + s)*WEIGHT_W
	typedef logic [PE*SIMD*WEIGHT_W-1:0] wTile_t;
	// Row r of the group sits at bits r*ACCU_W
	typedef logic [PE*ACCU_W-1:0] resVec_t;

	typedef logic [$clog2(SF)-1:0] sfIdx_t;
	typedef logic [$clog2(NF)-1:0] nfIdx_t;
	typedef logic [$clog2(OUT_CREDITS+1)-1:0] credit_t;

	// Replay FSM
	typedef enum logic [1:0] {loading, waitCredit, issuing} replayState_t;

endpackage

// File: rtl/mvuDotCore.sv
`timescale 1ns/1ns

module mvuDotCore
	import mvuGeomPkg::*, mvuDataPkg::*;
(
	input logic clk,
	input logic rst,
	mvuLaneIf.core lane,
	output logic vld,	// p holds a finished row group
	output resVec_t p
);
	logic [1:CORE_LATENCY] lastPipe;	// Last flag follows the data
	wTile_t wS1;
	actVec_t aS1;
	logic signed [PROD_W-1:0] prodS2 [PE][SIMD];
	accu_t tree [PE][2*SIMD-1];	// Root at 0, leaves from SIMD-1
	accu_t sumS3 [PE];
	accu_t accS4 [PE];

	always_ff @(posedge clk) begin
		if (rst) begin
			lastPipe <= '0;
		end else begin
			lastPipe <= {lane.last, lastPipe[1:CORE_LATENCY-1]};
		end
	end
	assign vld = lastPipe[CORE_LATENCY];

	// Stage 1, input registers with zero gating
	always_ff @(posedge clk) begin
		if (lane.zero) begin
			wS1 <= '0;
			aS1 <= '0;
		end else begin
			wS1 <= lane.wTile;
			aS1 <= lane.act;
		end
	end

	// Stage 2, signed weight times unsigned activation
	always_ff @(posedge clk) begin
		for (int r = 0; r < PE; r++) begin
			for (int s = 0; s < SIMD; s++) begin
				prodS2[r][s] <= weight_t'(wS1[(r*SIMD + s)*WEIGHT_W +: WEIGHT_W])
					* $signed({1'b0, act_t'(aS1[s*ACT_W +: ACT_W])});	// Zero-extend
			end
		end
	end

	// Adder tree across SIMD, one per row
	always_comb begin
		for (int r = 0; r < PE; r++) begin
			for (int s = 0; s < SIMD; s++) begin
				tree[r][SIMD-1+s] = accu_t'(prodS2[r][s]);	// Sign-extended leaf
			end
			for (int n = SIMD - 2; n >= 0; n--) begin
				tree[r][n] = tree[r][2*n+1] + tree[r][2*n+2];
			end
		end
	end

	// Stage 3, row sums
	always_ff @(posedge clk) begin
		for (int r = 0; r < PE; r++) begin
			sumS3[r] <= tree[r][0];
		end
	end

	// Stage 4, accumulate
	// lastPipe[4] marks the previous beat as a fold end, so this beat starts afresh
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < PE; r++) begin
				accS4[r] <= '0;
			end
		end else begin
			for (int r = 0; r < PE; r++) begin
				accS4[r] <= (lastPipe[4] ? '0 : accS4[r]) + sumS3[r];
			end
		end
	end

	// Stage 5, result register, lowest row in the low bits
	always_ff @(posedge clk) begin
		for (int r = 0; r < PE; r++) begin
			p[r*ACCU_W +: ACCU_W] <= accS4[r];
		end
	end

	// Result only for a real last beat CORE_LATENCY cycles back
	vldCause: assert property (@(posedge clk) disable iff (rst)
		vld |-> $past(lane.last && lane.beat, CORE_LATENCY));

endmodule

// File: rtl/mvuGeomPkg.sv
package mvuGeomPkg;

	// Matrix shape, rows of signed weights times columns of activations
	localparam int MW = 8;	// Matrix columns
	localparam int MH = 4;	// Matrix rows

	// Folding onto the datapath
	localparam int PE = 2;	// Rows per beat
	localparam int SIMD = 4;	// Columns per beat
	localparam int SF = MW / SIMD;	// Synapse folds, beats per row group
	localparam int NF = MH / PE;	// Neuron folds, row groups per vector

	// Output credits the consumer grants at reset
	localparam int OUT_CREDITS = 3;

	// Last lane beat to core vld
	localparam int CORE_LATENCY = 5;

	// Weight tiles, one hex line per tile, tile index nf*SF + sf
	localparam string WEIGHT_FILE = "rtl/weights.mem";

endpackage

// File: rtl/mvuLaneIf.sv
`timescale 1ns/1ns

// One beat into the dot-product core
interface mvuLaneIf
	import mvuDataPkg::*;
();
	logic beat;	// Beat carries data
	logic last;	// Final synapse fold of a neuron fold
	logic zero;	// Force this partial product to zero
	wTile_t wTile;	// PE x SIMD weights
	actVec_t act;	// SIMD activations

	// Weight ROM side
	modport weightSide (
		output wTile
	);

	// Activation replay side, also owns the beat flags
	modport actSide (
		output beat, last, zero, act
	);

	// Dot-product core
	modport core (
		input beat, last, zero, wTile, act
	);

endinterface

// File: rtl/mvuTop.sv
`timescale 1ns/1ns

module mvuTop
	import mvuDataPkg::*;
(
	input logic clk,
	input logic rst,

	// Input stream, one word per credit
	input logic inValid,
	input actVec_t inData,
	output logic inCredit,

	// Result stream
	output logic outValid,
	output resVec_t outData,
	input logic outCreditReturn
);
	logic issue;	// Beat request to both readers
	nfIdx_t nfIdx;
	sfIdx_t sfIdx;

	mvuLaneIf lane_i ();

	// Buffers vectors and runs the folds
	activationReplay replay_i (
		.clk (clk),
		.rst (rst),
		.inValid (inValid),
		.inData (inData),
		.inCredit (inCredit),
		.outValid (outValid),	// Core result fed back for credit tracking
		.outCreditReturn (outCreditReturn),
		.issue (issue),
		.nfIdx (nfIdx),
		.sfIdx (sfIdx),
		.lane (lane_i.actSide)
	);

	// Weight tile per fold pair
	weightFetch fetch_i (
		.clk (clk),
		.issue (issue),
		.nfIdx (nfIdx),
		.sfIdx (sfIdx),
		.lane (lane_i.weightSide)
	);

	mvuDotCore core_i (
		.clk (clk),
		.rst (rst),
		.lane (lane_i.core),
		.vld (outValid),
		.p (outData)
	);

endmodule

// File: rtl/weightFetch.sv
`timescale 1ns/1ns

module weightFetch
	import mvuGeomPkg::*, mvuDataPkg::*;
(
	input logic clk,
	input logic issue,	// Beat requested this cycle
	input nfIdx_t nfIdx,
	input sfIdx_t sfIdx,
	mvuLaneIf.weightSide lane
);
	wTile_t rom [NF*SF];	// One tile per fold pair
	logic [$clog2(NF*SF)-1:0] addr;

	// Tile order in the file is nf*SF + sf
	initial begin
		$readmemh(WEIGHT_FILE, rom);
	end

	// SF is a power of two, so the fold indices just concatenate
	assign addr = {nfIdx, sfIdx};

	// Registered read, lands with the replayed activations
	always_ff @(posedge clk) begin
		if (issue) begin
			lane.wTile <= rom[addr];	// Hold between beats
		end
	end

	// Replay must only address tiles that exist and were loaded
	romRange: assert property (@(posedge clk)
		issue |-> !$isunknown(rom[addr]));

endmodule

// File: rtl/weights.mem
// One weight tile per line, in tile order nf*SF + sf
// Row r, column s of a tile sits in nibble r*SIMD + s, nibble 0 lowest
7F18A2C9
E5308D6B
19F7C4A8
6D2B0E73

// File: sources.f
rtl/mvuGeomPkg.sv
rtl/mvuDataPkg.sv
rtl/mvuLaneIf.sv
rtl/activationReplay.sv
rtl/weightFetch.sv
rtl/mvuDotCore.sv
rtl/mvuTop.sv
testbench/mvuTb.sv

// File: testbench/mvuTb.sv
`timescale 1ns/1ns

module mvuTb
	import mvuGeomPkg::*, mvuDataPkg::*;
();
	localparam int NUM_VEC = 6;	// Table rows
	localparam int NUM_RUNS = 2;	// Held credits first, then immediate credits
	localparam int NUM_RES = NUM_RUNS * NUM_VEC * NF;	// Results in the whole run
	localparam int MAX_DELAY = 12;	// Longest credit hold in cycles
	localparam int IDLE_CYCLES = 10;
	localparam int TIMEOUT = 16 + NUM_RUNS * NUM_VEC * NF * (SF + CORE_LATENCY + 1)
		+ MAX_DELAY * NUM_RES + 50;

	logic clk;
	logic rst;
	logic inValid;
	actVec_t inData;
	logic inCredit;
	logic outValid;
	resVec_t outData;
	logic outCreditReturn = 1'b0;

	wTile_t weightTiles [NF*SF];	// Own copy of the weight ROM
	// Word 0 holds columns 0 to 3, column 0 in the low nibble
	actVec_t stimWords [NUM_VEC][SF] = '{
		'{16'h0000, 16'h0000},	// All zero
		'{16'hFFFF, 16'hFFFF},	// All maximum
		'{16'h4321, 16'h8765},
		'{16'h0F0F, 16'hF0F0},
		'{16'hCA98, 16'h1248},
		'{16'h7777, 16'h1000}
	};
	accu_t expRows [NUM_VEC][MH];	// Reference model fills this

	integer seed = 32'h7659_31ff;
	int errors = 0;
	int tests = 0;
	int cycleCount = 0;
	int wordsSent = 0;
	int inCreditsSeen = 0;
	int resultsGot = 0;
	int creditsReturned = 0;
	int lastResultCycle = 0;
	int dueQ [$];	// Cycle at which each held credit goes back

	mvuTop dut_i (
		.clk (clk),
		.rst (rst),
		.inValid (inValid),
		.inData (inData),
		.inCredit (inCredit),
		.outValid (outValid),
		.outData (outData),
		.outCreditReturn (outCreditReturn)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	task automatic checkResult(input accu_t got, input accu_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkCredit(input credit_t got, input credit_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic reportTest(input string name, input int errBefore);
		tests++;
		$display("Test %0d %s: %s", tests, name, errors == errBefore ? "ok" : "wrong");
	endtask

	// Row dot product, signed weight times unsigned activation
	function automatic accu_t refRow(input int v, input int row);
		int nf;
		int r;
		int sum;
		weight_t w;
		act_t a;
		nf = row / PE;
		r = row % PE;
		sum = 0;
		for (int fold = 0; fold < SF; fold++) begin
			for (int s = 0; s < SIMD; s++) begin
				w = weightTiles[nf*SF + fold][(r*SIMD + s)*WEIGHT_W +: WEIGHT_W];
				a = stimWords[v][fold][s*ACT_W +: ACT_W];
				sum += int'(w) * int'(a);	// Sign-extended times zero-extended
			end
		end
		return accu_t'(sum);
	endfunction

	// Producer, one word per held credit
	task automatic sendPass();
		int v;
		int w;
		v = 0;
		w = 0;
		while (v < NUM_VEC) begin
			@(posedge clk);
			#2;
			if (SF + inCreditsSeen - wordsSent > 0) begin
				inValid = 1'b1;
				inData = stimWords[v][w];
				wordsSent++;
				w++;
				if (w == SF) begin
					w = 0;
					v++;
				end
			end else begin
				inValid = 1'b0;	// Out of credits
			end
		end
		@(posedge clk);
		#2;
		inValid = 1'b0;
	endtask

	task automatic waitDrain(input int count);
		while (resultsGot < count || creditsReturned < resultsGot) begin
			@(negedge clk);
		end
	endtask

	// Monitor and consumer
	always @(posedge clk) begin : monitor
		int vec;
		int fold;
		int gap;
		int delay;
		int errBefore;
		cycleCount++;
		if (cycleCount > TIMEOUT) begin
			$display("Timeout: run passed %0d cycles with %0d of %0d results", TIMEOUT,
				resultsGot, NUM_RES);
			$display("Done: errors found");
			$finish;
		end else begin
			if (!rst && inCredit) begin
				inCreditsSeen++;
				// Pulse p belongs to vector (p-1)/SF, whose words must all be in
				if (wordsSent < ((inCreditsSeen - 1) / SF + 1) * SF) begin
					errors++;
					$display("Error at %0t ns: input credit returned before its vector was complete",
						$time);
				end
			end
			#2;	// Result read in its own cycle, so its credit can go back in that cycle
			if (!rst && outValid) begin
				errBefore = errors;
				vec = (resultsGot / NF) % NUM_VEC;
				fold = resultsGot % NF;	// Fold 0 comes first
				gap = cycleCount - lastResultCycle;
				resultsGot++;
				if (resultsGot > OUT_CREDITS + creditsReturned) begin
					errors++;
					$display("Error at %0t ns: more results than output credits given", $time);
				end
				for (int r = 0; r < PE; r++) begin
					checkResult(outData[r*ACCU_W +: ACCU_W], expRows[vec][fold*PE + r],
						$sformatf("vector %0d row %0d", vec, fold*PE + r));
				end
				// Second pass returns credits at once
				if (resultsGot > NUM_VEC * NF && fold != 0 && gap > SF) begin
					errors++;
					$display("Error at %0t ns: fold results %0d cycles apart", $time, gap);
				end
				lastResultCycle = cycleCount;
				delay = (resultsGot > NUM_VEC * NF) ? 0 : $unsigned($random(seed)) % (MAX_DELAY + 1);
				dueQ.push_back(cycleCount + delay);
				reportTest($sformatf("vector %0d fold %0d", vec, fold), errBefore);
			end
			outCreditReturn = 1'b0;
			if (dueQ.size() > 0 && dueQ[0] <= cycleCount) begin
				void'(dueQ.pop_front());
				outCreditReturn = 1'b1;	// One credit per cycle
				creditsReturned++;
			end
		end
	end

	initial begin
		int errBefore;
		rst = 1'b1;
		inValid = 1'b0;
		inData = '0;
		$readmemh(WEIGHT_FILE, weightTiles);
		for (int v = 0; v < NUM_VEC; v++) begin
			for (int row = 0; row < MH; row++) begin
				expRows[v][row] = refRow(v, row);
			end
		end
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;

		// Nothing may come out before any input
		errBefore = errors;
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			if (outValid || inCredit) begin
				errors++;
				$display("Error at %0t ns: DUT output active with no input", $time);
			end
		end
		reportTest("idle after reset", errBefore);

		sendPass();	// Consumer holds credits at random
		waitDrain(NUM_VEC * NF);
		sendPass();	// Consumer returns credits at once
		waitDrain(NUM_RES);
		repeat (CORE_LATENCY + 2) @(negedge clk);

		// Both credit pools back at their reset values
		errBefore = errors;
		checkCredit(credit_t'(SF + inCreditsSeen - wordsSent), credit_t'(SF),
			"producer input credits");
		checkCredit(dut_i.replay_i.outCredits, credit_t'(OUT_CREDITS), "DUT output credits");
		if (resultsGot != NUM_RES || inCreditsSeen != NUM_RUNS * NUM_VEC * SF) begin
			errors++;
			$display("Fail at %0t ns: %0d results and %0d input credits, expected %0d and %0d",
				$time, resultsGot, inCreditsSeen, NUM_RES, NUM_RUNS * NUM_VEC * SF);
		end
		reportTest("credits after drain", errBefore);

		$display("Summary: %0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
